//--- icache.f
+incdir+.
icache_pkg.sv
icache_array_if.sv
icache_array.sv
icache_ctrl.sv
icache_top.sv
tb_icache_mem.sv
tb_icache.sv

//--- icache_array.sv
`timescale 1ns/1ps
`include "icache_macros.svh"

module icache_array (
    input logic           clk,
    input logic           rst,
    icache_array_if.array bus
);

    // ****************************************
    // Line storage
    // ****************************************

    // One valid bit per line
    logic [`ICACHE_LINES-1:0] valid;

    icache_pkg::icache_tag_t tags [`ICACHE_LINES];

    logic [`ICACHE_WORD_BITS-1:0] words [`ICACHE_LINES];

    // ****************************************
    // Valid bits
    // ****************************************

    // A flush wipes the whole cache in one edge
    // A fill marks only its own line
    always_ff @(posedge clk)
    begin
        if (rst || bus.flush_en)
        begin
            valid <= '0;
        end
        else if (bus.fill_en)
        begin
            valid[bus.index] <= 1'b1;
        end
    end

    // ****************************************
    // Tag and data write
    // ****************************************

    always_ff @(posedge clk)
    begin
        if (bus.fill_en)
        begin
            tags[bus.index]  <= bus.fill_tag;
            words[bus.index] <= bus.fill_data;
        end
    end

    // ****************************************
    // Lookup
    // ****************************************

    // The controller sees the indexed line in the same cycle
    // After a fill the new contents show up one edge later
    always_comb
    begin
        bus.line_valid = valid[bus.index];
        bus.line_tag   = tags[bus.index];
        bus.line_data  = words[bus.index];
    end

endmodule

//--- icache_array_if.sv
`timescale 1ns/1ps
`include "icache_macros.svh"

interface icache_array_if;

    // Lookup and fill controls from the controller
    icache_pkg::icache_index_t       index;
    logic                            fill_en;
    icache_pkg::icache_tag_t         fill_tag;
    logic [`ICACHE_WORD_BITS-1:0]    fill_data;
    logic                            flush_en;

    // Contents of the indexed line, read combinationally
    logic                            line_valid;
    icache_pkg::icache_tag_t         line_tag;
    logic [`ICACHE_WORD_BITS-1:0]    line_data;

    modport ctrl (
        output index, fill_en, fill_tag, fill_data, flush_en,
        input  line_valid, line_tag, line_data
    );

    modport array (
        input  index, fill_en, fill_tag, fill_data, flush_en,
        output line_valid, line_tag, line_data
    );

endinterface

//--- icache_ctrl.sv
`timescale 1ns/1ps
`include "icache_macros.svh"

module icache_ctrl (
    input  logic                         clk,
    input  logic                         rst,

    // CPU fetch port
    input  logic [`ICACHE_WORD_BITS-1:0] cpu_req_addr,
    input  logic                         cpu_req_valid,
    input  logic                         flush,
    output logic [`ICACHE_WORD_BITS-1:0] cpu_req_data,
    output logic                         cpu_req_ready,

    // Instruction memory port
    input  logic [`ICACHE_WORD_BITS-1:0] mem_req_data,
    input  logic                         mem_req_ready,
    output logic [`ICACHE_WORD_BITS-1:0] mem_req_addr,
    output logic                         mem_req_valid,

    icache_array_if.ctrl                 bus
);

    icache_pkg::icache_state_e state;
    icache_pkg::icache_state_e state_next;

    // Address of the request in flight
    icache_pkg::icache_addr_u req_addr;

    logic accept;
    logic tag_match;
    logic hit;
    logic miss;

    // ****************************************
    // Lookup decode
    // ****************************************

    // A flush in IDLE wins over a waiting request
    assign accept = (state == icache_pkg::IDLE) && !flush && cpu_req_valid;

    assign tag_match = (bus.line_tag == req_addr.fields.tag);

    assign hit  = (state == icache_pkg::COMPARE) && bus.line_valid && tag_match;
    assign miss = (state == icache_pkg::COMPARE) && !(bus.line_valid && tag_match);

    // ****************************************
    // Array controls
    // ****************************************

    assign bus.index = req_addr.fields.index;

    assign bus.flush_en = (state == icache_pkg::IDLE) && flush;

    // The returned word is written in the same edge that sees mem_req_ready
    assign bus.fill_en   = (state == icache_pkg::ALLOCATE) && mem_req_ready;
    assign bus.fill_tag  = req_addr.fields.tag;
    assign bus.fill_data = mem_req_data;

    // ****************************************
    // State machine
    // ****************************************

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= icache_pkg::IDLE;
        end
        else
        begin
            state <= state_next;
        end
    end

    always_comb
    begin
        state_next = state;
        case (state)
            icache_pkg::IDLE:
            begin
                if (accept)
                begin
                    state_next = icache_pkg::COMPARE;
                end
            end
            icache_pkg::COMPARE:
            begin
                // A miss comes back here after the fill and then hits
                state_next = hit ? icache_pkg::IDLE : icache_pkg::ALLOCATE;
            end
            icache_pkg::ALLOCATE:
            begin
                if (mem_req_ready)
                begin
                    state_next = icache_pkg::COMPARE;
                end
            end
            default:
            begin
                state_next = icache_pkg::IDLE;
            end
        endcase
    end

    // ****************************************
    // Request capture
    // ****************************************

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            req_addr.word <= cpu_req_addr;
        end
    end

    // ****************************************
    // CPU response
    // ****************************************

    // Ready is a single cycle pulse, data holds until the next hit
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            cpu_req_ready <= 1'b0;
        end
        else
        begin
            cpu_req_ready <= hit;
        end
    end

    always_ff @(posedge clk)
    begin
        if (hit)
        begin
            cpu_req_data <= bus.line_data;
        end
    end

    // ****************************************
    // Memory refill
    // ****************************************

    // Valid is held as a level until memory answers
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            mem_req_valid <= 1'b0;
        end
        else if (miss)
        begin
            mem_req_valid <= 1'b1;
        end
        else if (bus.fill_en)
        begin
            mem_req_valid <= 1'b0;
        end
    end

    // Memory only ever sees word aligned addresses
    always_ff @(posedge clk)
    begin
        if (miss)
        begin
            mem_req_addr <= {req_addr.word[`ICACHE_WORD_BITS-1:`ICACHE_OFFSET_BITS],
                             {`ICACHE_OFFSET_BITS{1'b0}}};
        end
    end

endmodule

//--- icache_macros.svh
`ifndef ICACHE_MACROS_SVH
`define ICACHE_MACROS_SVH

// ****************************************
// Cache geometry
// ****************************************

// Width of one instruction word and of a fetch address
`define ICACHE_WORD_BITS 32

// Address bits 1:0 select a byte inside the word and are ignored
`define ICACHE_OFFSET_BITS 2

// Address bits 5:2 select one of the lines
`define ICACHE_INDEX_BITS 4

`define ICACHE_LINES 16

// Everything above the index is tag, so no two word addresses alias
`define ICACHE_TAG_BITS 26

`endif

//--- icache_pkg.sv
`include "icache_macros.svh"

package icache_pkg;

    // ****************************************
    // Address fields
    // ****************************************

    typedef logic [`ICACHE_TAG_BITS-1:0] icache_tag_t;

    typedef logic [`ICACHE_INDEX_BITS-1:0] icache_index_t;

    // One fetch address seen two ways
    // The raw word goes to memory, the fields drive the lookup
    typedef union packed {
        logic [`ICACHE_WORD_BITS-1:0] word;
        struct packed {
            icache_tag_t                    tag;
            icache_index_t                  index;
            logic [`ICACHE_OFFSET_BITS-1:0] offset;
        } fields;
    } icache_addr_u;

    // ****************************************
    // Controller states
    // ****************************************

    // IDLE waits for a request or a flush
    // COMPARE checks the indexed line and answers on a hit
    // ALLOCATE holds the memory request until the word comes back
    typedef enum logic [1:0] {
        IDLE,
        COMPARE,
        ALLOCATE
    } icache_state_e;

endpackage

//--- icache_top.sv
`timescale 1ns/1ps
`include "icache_macros.svh"

module icache_top (
    input  logic                         clk,
    input  logic                         rst,

    // CPU fetch port
    input  logic [`ICACHE_WORD_BITS-1:0] cpu_req_addr,
    input  logic                         cpu_req_valid,
    input  logic                         flush,
    output logic [`ICACHE_WORD_BITS-1:0] cpu_req_data,
    output logic                         cpu_req_ready,

    // Instruction memory port
    input  logic [`ICACHE_WORD_BITS-1:0] mem_req_data,
    input  logic                         mem_req_ready,
    output logic [`ICACHE_WORD_BITS-1:0] mem_req_addr,
    output logic                         mem_req_valid
);

    // ****************************************
    // Controller to array link
    // ****************************************

    icache_array_if array_bus ();

    // ****************************************
    // Controller
    // ****************************************

    icache_ctrl ctrl0 (
        .clk           (clk),
        .rst           (rst),
        .cpu_req_addr  (cpu_req_addr),
        .cpu_req_valid (cpu_req_valid),
        .flush         (flush),
        .cpu_req_data  (cpu_req_data),
        .cpu_req_ready (cpu_req_ready),
        .mem_req_data  (mem_req_data),
        .mem_req_ready (mem_req_ready),
        .mem_req_addr  (mem_req_addr),
        .mem_req_valid (mem_req_valid),
        .bus           (array_bus.ctrl)
    );

    // ****************************************
    // Storage
    // ****************************************

    icache_array array0 (
        .clk (clk),
        .rst (rst),
        .bus (array_bus.array)
    );

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the instruction cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f icache.f --top-module tb_icache -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_icache)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation executable returned status $status"
    exit 1
fi

if echo "$output" | grep -q "^Simulation passed$"; then
    exit 0
fi
exit 1

//--- tb_icache.sv
`timescale 1ns/1ps
`include "icache_macros.svh"

module tb_icache;

    localparam int max_fetches  = 260;
    localparam int fetch_cycles = 16;
    localparam int timeout_ns   = (max_fetches * fetch_cycles * 2 + 200) * 4;

    logic                         clk;
    logic                         rst;
    logic [`ICACHE_WORD_BITS-1:0] cpu_req_addr;
    logic                         cpu_req_valid;
    logic                         flush;
    logic [`ICACHE_WORD_BITS-1:0] cpu_req_data;
    logic                         cpu_req_ready;
    logic [`ICACHE_WORD_BITS-1:0] mem_req_data;
    logic                         mem_req_ready;
    logic [`ICACHE_WORD_BITS-1:0] mem_req_addr;
    logic                         mem_req_valid;
    logic [`ICACHE_WORD_BITS-1:0] mem_key;
    logic [3:0]                   mem_latency;
    logic [31:0]                  mem_served;
    logic [`ICACHE_WORD_BITS-1:0] mem_last_addr;

    // Expected contents of the cache lines
    logic [`ICACHE_LINES-1:0]     ref_valid;
    logic [`ICACHE_TAG_BITS-1:0]  ref_tag [`ICACHE_LINES];
    logic [`ICACHE_WORD_BITS-1:0] ref_data [`ICACHE_LINES];

    int          errors;
    int          checks;

    icache_top dut0 (.*);

    tb_icache_mem mem0 (
        .clk           (clk),
        .rst           (rst),
        .mem_req_addr  (mem_req_addr),
        .mem_req_valid (mem_req_valid),
        .mem_req_data  (mem_req_data),
        .mem_req_ready (mem_req_ready),
        .key           (mem_key),
        .latency       (mem_latency),
        .served        (mem_served),
        .last_addr     (mem_last_addr)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ****************************************
    // Helpers
    // ****************************************

    function automatic logic [`ICACHE_WORD_BITS-1:0] make_addr(
        input logic [`ICACHE_TAG_BITS-1:0]    tag,
        input logic [`ICACHE_INDEX_BITS-1:0]  index,
        input logic [`ICACHE_OFFSET_BITS-1:0] offset
    );
        return {tag, index, offset};
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        checks++;
        assert (got == expected)
        else
        begin
            errors++;
            $display("FAIL %0t %s got %h expected %h", $time, name, got, expected);
        end
    endtask

    task automatic apply_reset();
        rst = 1'b1;
        repeat (10) @(negedge clk);
        rst = 1'b0;
        ref_valid = '0;
    endtask

    task automatic flush_cache();
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        ref_valid = '0;
    endtask

    // One fetch, predicted by the line model and checked against memory traffic
    task automatic fetch_and_check(input logic [`ICACHE_WORD_BITS-1:0] addr);
        logic [`ICACHE_INDEX_BITS-1:0] idx;
        logic [`ICACHE_TAG_BITS-1:0]   tag;
        logic [`ICACHE_WORD_BITS-1:0]  aligned;
        logic [`ICACHE_WORD_BITS-1:0]  expected;
        logic [31:0]                   served_before;
        logic                          predict_hit;
        int                            cycles;

        idx           = addr[`ICACHE_OFFSET_BITS +: `ICACHE_INDEX_BITS];
        tag           = addr[`ICACHE_WORD_BITS-1 -: `ICACHE_TAG_BITS];
        aligned       = {addr[`ICACHE_WORD_BITS-1:`ICACHE_OFFSET_BITS], 2'b00};
        predict_hit   = ref_valid[idx] && (ref_tag[idx] == tag);
        expected      = predict_hit ? ref_data[idx] : (aligned ^ mem_key);
        served_before = mem_served;
        mem_latency   = 4'($urandom_range(1, 8));
        cpu_req_addr  = addr;
        cpu_req_valid = 1'b1;
        cycles        = 0;
        do
        begin
            @(negedge clk);
            cycles++;
        end
        while (!cpu_req_ready);
        cpu_req_valid = 1'b0;

        check_value("cpu_req_data", cpu_req_data, expected);
        if (predict_hit)
        begin
            check_value("hit latency", cycles, 2);
            check_value("memory request count", mem_served, served_before);
        end
        else
        begin
            check_value("memory request count", mem_served, served_before + 32'd1);
            check_value("mem_req_addr", mem_last_addr, aligned);
        end
        ref_valid[idx] = 1'b1;
        ref_tag[idx]   = tag;
        ref_data[idx]  = expected;
    endtask

    // ****************************************
    // Tests
    // ****************************************

    task automatic test_cold_miss();
        fetch_and_check(make_addr(26'h0_1234, 4'd3, 2'b11));
    endtask

    // Byte offsets differ but the word is the same line
    task automatic test_hit_timing();
        fetch_and_check(make_addr(26'h0_1234, 4'd3, 2'b00));
        fetch_and_check(make_addr(26'h0_1234, 4'd3, 2'b10));
        fetch_and_check(make_addr(26'h0_1234, 4'd3, 2'b11));
    endtask

    task automatic test_conflict();
        for (int i = 0; i < 3; i++)
        begin
            fetch_and_check(make_addr(26'h2_0001, 4'd9, 2'b00));
            fetch_and_check(make_addr(26'h3_0777, 4'd9, 2'b00));
        end
    endtask

    task automatic test_stale_flush();
        logic [`ICACHE_WORD_BITS-1:0] addrs [4];

        addrs[0] = make_addr(26'h0_0abc, 4'd0, 2'b00);
        addrs[1] = make_addr(26'h1_5555, 4'd5, 2'b01);
        addrs[2] = make_addr(26'h3_ffff, 4'd10, 2'b00);
        addrs[3] = make_addr(26'h0_0042, 4'd15, 2'b10);
        foreach (addrs[i])
        begin
            fetch_and_check(addrs[i]);
        end
        // The cache keeps the old words until it is flushed
        mem_key = mem_key ^ 32'hffff_0000;
        foreach (addrs[i])
        begin
            fetch_and_check(addrs[i]);
        end
        flush_cache();
        foreach (addrs[i])
        begin
            fetch_and_check(addrs[i]);
        end
    endtask

    task automatic test_random();
        logic [`ICACHE_WORD_BITS-1:0] pool [40];
        logic [5:0]                   pick;

        foreach (pool[i])
        begin
            pool[i] = $urandom;
        end
        for (int n = 0; n < 200; n++)
        begin
            pick = 6'($urandom_range(0, 39));
            fetch_and_check(pool[pick]);
        end
    endtask

    task automatic test_reset();
        logic [`ICACHE_WORD_BITS-1:0] addrs [3];
        logic [31:0]                  served_before;

        addrs[0] = make_addr(26'h0_0777, 4'd1, 2'b00);
        addrs[1] = make_addr(26'h2_4680, 4'd7, 2'b00);
        addrs[2] = make_addr(26'h1_1357, 4'd12, 2'b11);
        foreach (addrs[i])
        begin
            fetch_and_check(addrs[i]);
        end
        // Leave a refill pending so the reset has state to clear
        mem_latency   = 4'd8;
        cpu_req_addr  = make_addr(26'h0_0999, 4'd4, 2'b00);
        cpu_req_valid = 1'b1;
        do
        begin
            @(negedge clk);
        end
        while (!mem_req_valid);
        cpu_req_valid = 1'b0;
        apply_reset();
        served_before = mem_served;
        repeat (5)
        begin
            @(negedge clk);
            check_value("cpu_req_ready", 32'(cpu_req_ready), 0);
            check_value("mem_req_valid", 32'(mem_req_valid), 0);
        end
        check_value("memory request count", mem_served, served_before);
        // The model is empty again, so every one of these must miss
        foreach (addrs[i])
        begin
            fetch_and_check(addrs[i]);
        end
    endtask

    // ****************************************
    // Main sequence and watchdog
    // ****************************************

    initial
    begin
        void'($urandom(77496));
        rst           = 1'b1;
        cpu_req_addr  = '0;
        cpu_req_valid = 1'b0;
        flush         = 1'b0;
        mem_key       = 32'h5a5a_c3c3;
        mem_latency   = 4'd1;
        errors        = 0;
        checks        = 0;
        apply_reset();
        test_cold_miss();
        test_hit_timing();
        test_conflict();
        test_stale_flush();
        test_random();
        test_reset();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
        begin
            $display("Simulation passed");
        end
        else
        begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial
    begin
        #(timeout_ns);
        $display("Timeout after %0d ns, the cache stopped answering requests", timeout_ns);
        $display("Simulation failed");
        $finish;
    end

endmodule

//--- tb_icache_mem.sv
`timescale 1ns/1ps
`include "icache_macros.svh"

module tb_icache_mem (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [`ICACHE_WORD_BITS-1:0] mem_req_addr,
    input  logic                         mem_req_valid,
    output logic [`ICACHE_WORD_BITS-1:0] mem_req_data,
    output logic                         mem_req_ready,
    input  logic [`ICACHE_WORD_BITS-1:0] key,
    input  logic [3:0]                   latency,
    output logic [31:0]                  served,
    output logic [`ICACHE_WORD_BITS-1:0] last_addr
);

    logic       busy;
    logic [3:0] wait_left;

    // Everything moves on the falling edge so the cache samples settled values
    // The returned word is the request address mixed with the current key
    always @(negedge clk)
    begin
        mem_req_ready <= 1'b0;
        if (rst)
        begin
            busy         <= 1'b0;
            wait_left    <= '0;
            served       <= '0;
            last_addr    <= '0;
            mem_req_data <= '0;
        end
        else if (busy)
        begin
            if (wait_left == 4'd0)
            begin
                mem_req_ready <= 1'b1;
                mem_req_data  <= mem_req_addr ^ key;
                busy          <= 1'b0;
            end
            else
            begin
                wait_left <= wait_left - 4'd1;
            end
        end
        else if (mem_req_valid && !mem_req_ready)
        begin
            busy      <= 1'b1;
            wait_left <= latency - 4'd1;
            served    <= served + 32'd1;
            last_addr <= mem_req_addr;
        end
    end

endmodule
